// File: hw/sfm_defs.svh
`ifndef SFM_DEFS_SVH
`define SFM_DEFS_SVH

// addend, unsigned Q0.16
`define SFM_ADD_W 16

// factor, unsigned Q1.15
`define SFM_FACT_W 16

// accumulator, operands and result, signed Q16.16
`define SFM_ACC_W 32
`define SFM_FRAC_W 16

// multiply-add depth, one partial sum per stage
`define SFM_MAC_STAGES 3

// reciprocal
`define SFM_INV_ITERS 2
`define SFM_SEED_BITS 3

`endif

// File: hw/sfm_pkg.sv
`include "sfm_defs.svh"
`default_nettype none

package sfm_pkg;

    typedef logic [`SFM_ADD_W-1:0] add_t;
    typedef logic [`SFM_FACT_W-1:0] fact_t;
    typedef logic signed [`SFM_ACC_W-1:0] acc_t;
    typedef logic [$clog2(`SFM_MAC_STAGES)-1:0] slot_t;

    // run sequencing of the accumulator
    typedef enum logic [2:0] {
        IDLE,
        COMPUTING,
        DRAINING,
        REDUCTION,
        INVERTING,
        FINISHED
    } sum_state_e;

    // newton-raphson sequencing
    typedef enum logic [2:0] {
        INV_IDLE,
        INV_SEED,
        INV_ERR_OP,
        INV_MUL_OP,
        INV_DONE
    } inv_state_e;

endpackage

`default_nettype wire

// File: hw/sfm_mac_pipe.sv
`include "sfm_defs.svh"
`default_nettype none

module sfm_mac_pipe
    import sfm_pkg::*;
(
    input  wire logic  clk_i,
    input  wire logic  rst_ni,
    input  wire logic  clear_i,
    input  wire logic  sum_req_valid_i,
    input  wire acc_t  sum_a_i,
    input  wire acc_t  sum_b_i,
    input  wire acc_t  sum_c_i,
    input  wire slot_t sum_slot_i,
    input  wire logic  inv_req_valid_i,
    input  wire acc_t  inv_a_i,
    input  wire acc_t  inv_b_i,
    input  wire acc_t  inv_c_i,
    output logic       mac_valid_o,
    output acc_t       mac_res_o,
    output slot_t      mac_slot_o
);

    localparam int unsigned STAGES = `SFM_MAC_STAGES;

    logic                           req_valid;
    acc_t                           op_a;
    acc_t                           op_b;
    acc_t                           op_c;
    slot_t                          op_slot;
    logic signed [2*`SFM_ACC_W-1:0] prod_full;

    acc_t                           prod_q;
    acc_t                           c_q;
    acc_t                           res_q [1:STAGES-1];
    logic [STAGES-1:0]              vld_q;
    slot_t                          slot_q [STAGES];

    // sum side wins, the two never overlap in practice
    always_comb begin
        req_valid = sum_req_valid_i | inv_req_valid_i;
        if (sum_req_valid_i) begin
            op_a    = sum_a_i;
            op_b    = sum_b_i;
            op_c    = sum_c_i;
            op_slot = sum_slot_i;
        end else begin
            op_a    = inv_a_i;
            op_b    = inv_b_i;
            op_c    = inv_c_i;
            op_slot = '0;
        end
    end

    assign prod_full = op_a * op_b;

    // stage 0 multiplies, stage 1 adds, the rest only delay
    always_ff @(posedge clk_i) begin
        prod_q   <= prod_full[`SFM_FRAC_W +: `SFM_ACC_W];
        c_q      <= op_c;
        res_q[1] <= prod_q + c_q;
        for (int i = 2; i < STAGES; i++) begin
            res_q[i] <= res_q[i-1];
        end
        slot_q[0] <= op_slot;
        for (int i = 1; i < STAGES; i++) begin
            slot_q[i] <= slot_q[i-1];
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            vld_q <= '0;
        end else if (clear_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[STAGES-2:0], req_valid};
        end
    end

    assign mac_valid_o = vld_q[STAGES-1];
    assign mac_res_o   = res_q[STAGES-1];
    assign mac_slot_o  = slot_q[STAGES-1];

endmodule

`default_nettype wire

// File: hw/sfm_sum_ctrl.sv
`include "sfm_defs.svh"
`default_nettype none

module sfm_sum_ctrl
    import sfm_pkg::*;
(
    input  wire logic  clk_i,
    input  wire logic  rst_ni,
    input  wire logic  clear_i,
    input  wire logic  add_valid_i,
    input  wire add_t  add_i,
    input  wire logic  mul_valid_i,
    input  wire fact_t mul_i,
    input  wire logic  finish_i,
    input  wire logic  inv_done_i,
    input  wire logic  mac_valid_i,
    input  wire acc_t  mac_res_i,
    input  wire slot_t mac_slot_i,
    output logic       req_valid_o,
    output acc_t       a_o,
    output acc_t       b_o,
    output acc_t       c_o,
    output slot_t      slot_o,
    output logic       inv_start_o,
    output acc_t       den_o,
    output logic       ready_o,
    output logic       valid_o,
    output logic       reducing_o
);

    localparam int unsigned STAGES = `SFM_MAC_STAGES;
    localparam int unsigned CNT_W  = $clog2(`SFM_MAC_STAGES + 1);
    localparam slot_t       LAST   = slot_t'(STAGES - 1);
    localparam acc_t        ONE    = acc_t'(1 << `SFM_FRAC_W);

    sum_state_e        state_q;
    sum_state_e        state_d;
    slot_t             slot_q;
    acc_t              part_q [STAGES];
    fact_t             fact_q;
    logic [CNT_W-1:0]  resc_cnt_q;
    logic [CNT_W-1:0]  drain_cnt_q;
    slot_t             red_idx_q;
    logic              red_first_q;

    logic              add_acc;
    logic              mul_acc;
    logic              finish_acc;
    logic              resc_issue;
    logic              red_issue;
    logic              red_last;
    logic              wb_en;
    slot_t             red_sel;
    acc_t              cur_part;
    acc_t              add_ext;
    acc_t              fact_ext;

    assign ready_o    = (state_q inside {IDLE, COMPUTING, FINISHED}) && (resc_cnt_q == '0);
    assign mul_acc    = mul_valid_i && ready_o;
    assign add_acc    = add_valid_i && ready_o && !mul_valid_i;
    assign finish_acc = finish_i && (state_q inside {IDLE, COMPUTING});
    assign resc_issue = resc_cnt_q != '0;
    assign red_last   = mac_valid_i && (red_idx_q == LAST);
    assign red_issue  = (state_q == REDUCTION) &&
                        (red_first_q || (mac_valid_i && red_idx_q != LAST));
    assign red_sel    = red_first_q ? '0 : red_idx_q + 1'b1;

    // results of our own reduction and of the inverter are not slot updates
    assign wb_en = !(state_q inside {REDUCTION, INVERTING});

    // bypass a result landing in the slot being issued
    assign cur_part = (mac_valid_i && wb_en && mac_slot_i == slot_q) ? mac_res_i
                                                                     : part_q[slot_q];

    assign add_ext  = acc_t'(add_i);
    assign fact_ext = acc_t'(fact_q) << (`SFM_FRAC_W - `SFM_FACT_W + 1);

    always_comb begin
        req_valid_o = 1'b0;
        a_o         = cur_part;
        b_o         = ONE;
        c_o         = '0;
        slot_o      = slot_q;
        if (red_issue) begin
            req_valid_o = 1'b1;
            a_o         = part_q[red_sel];
            c_o         = red_first_q ? '0 : mac_res_i;
            slot_o      = red_sel;
        end else if (resc_issue) begin
            // partial times factor
            req_valid_o = 1'b1;
            b_o         = fact_ext;
        end else if (add_acc) begin
            req_valid_o = 1'b1;
            a_o         = add_ext;
            c_o         = cur_part;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (finish_acc) begin
                    state_d = DRAINING;
                end else if (add_acc) begin
                    state_d = COMPUTING;
                end
            end
            COMPUTING: begin
                if (finish_acc) begin
                    state_d = DRAINING;
                end
            end
            DRAINING: begin
                if (drain_cnt_q == CNT_W'(1) && !resc_issue) begin
                    state_d = REDUCTION;
                end
            end
            REDUCTION: begin
                if (red_last) begin
                    state_d = INVERTING;
                end
            end
            INVERTING: begin
                if (inv_done_i) begin
                    state_d = FINISHED;
                end
            end
            FINISHED: begin
                if (add_acc) begin
                    state_d = COMPUTING;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= IDLE;
            slot_q      <= '0;
            resc_cnt_q  <= '0;
            drain_cnt_q <= '0;
            red_idx_q   <= '0;
            red_first_q <= 1'b0;
        end else if (clear_i) begin
            state_q     <= IDLE;
            slot_q      <= '0;
            resc_cnt_q  <= '0;
            drain_cnt_q <= '0;
            red_idx_q   <= '0;
            red_first_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            red_first_q <= (state_q == DRAINING) && (state_d == REDUCTION);
            // rescale issues stay in the round-robin, three of them wrap back
            if (add_acc || resc_issue) begin
                slot_q <= (slot_q == LAST) ? '0 : slot_q + 1'b1;
            end else if (state_q == REDUCTION) begin
                slot_q <= '0;
            end
            if (mul_acc) begin
                resc_cnt_q <= CNT_W'(STAGES);
            end else if (resc_issue) begin
                resc_cnt_q <= resc_cnt_q - 1'b1;
            end
            if (finish_acc) begin
                drain_cnt_q <= CNT_W'(STAGES);
            end else if (state_q == DRAINING) begin
                drain_cnt_q <= resc_issue ? CNT_W'(STAGES) : drain_cnt_q - 1'b1;
            end
            if (red_issue) begin
                red_idx_q <= red_sel;
            end
        end
    end

    // partial-sum bank, emptied once the reduction has read it
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < STAGES; i++) begin
                part_q[i] <= '0;
            end
        end else if (clear_i || inv_start_o) begin
            for (int i = 0; i < STAGES; i++) begin
                part_q[i] <= '0;
            end
        end else if (mac_valid_i && wb_en) begin
            part_q[mac_slot_i] <= mac_res_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mul_acc) begin
            fact_q <= mul_i;
        end
    end

    assign inv_start_o = (state_q == REDUCTION) && red_last;
    assign den_o       = mac_res_i;
    assign valid_o     = state_q == FINISHED;
    assign reducing_o  = state_q == REDUCTION;

endmodule

`default_nettype wire

// File: hw/sfm_inv_newton.sv
`include "sfm_defs.svh"
`default_nettype none

module sfm_inv_newton
    import sfm_pkg::*;
(
    input  wire logic clk_i,
    input  wire logic rst_ni,
    input  wire logic clear_i,
    input  wire logic start_i,
    input  wire acc_t den_i,
    input  wire logic mac_valid_i,
    input  wire acc_t mac_res_i,
    output logic      req_valid_o,
    output acc_t      a_o,
    output acc_t      b_o,
    output acc_t      c_o,
    output logic      done_o,
    output acc_t      inv_o
);

    localparam int unsigned SH_W   = $clog2(`SFM_ACC_W);
    localparam int unsigned ITER_W = $clog2(`SFM_INV_ITERS + 1);
    localparam acc_t        TWO    = acc_t'(2 << `SFM_FRAC_W);

    inv_state_e        state_q;
    inv_state_e        state_d;
    logic [SH_W-1:0]   msb;
    logic [SH_W-1:0]   sh_d;
    logic [SH_W-1:0]   sh_q;
    logic [ITER_W-1:0] iter_q;
    logic              last_iter;
    acc_t              d_q;
    acc_t              x_q;
    acc_t              seed;
    acc_t              inv_q;

    // leading one, then the shift that puts d in [0.5, 1)
    always_comb begin
        msb = '0;
        for (int i = 0; i < `SFM_ACC_W; i++) begin
            if (den_i[i]) begin
                msb = SH_W'(i);
            end
        end
        sh_d = (msb > SH_W'(`SFM_FRAC_W - 1)) ? msb - SH_W'(`SFM_FRAC_W - 1) : '0;
    end

    // 1/midpoint of each 1/16 wide bin
    always_comb begin
        case (d_q[`SFM_FRAC_W-2 -: `SFM_SEED_BITS])
            3'd0:    seed = 32'h0001_E1E2;
            3'd1:    seed = 32'h0001_AF28;
            3'd2:    seed = 32'h0001_8618;
            3'd3:    seed = 32'h0001_642D;
            3'd4:    seed = 32'h0001_47AE;
            3'd5:    seed = 32'h0001_2F68;
            3'd6:    seed = 32'h0001_1A7C;
            default: seed = 32'h0001_0842;
        endcase
    end

    assign last_iter = iter_q == ITER_W'(`SFM_INV_ITERS - 1);

    always_comb begin
        state_d     = state_q;
        req_valid_o = 1'b0;
        a_o         = -d_q;
        b_o         = seed;
        c_o         = TWO;
        case (state_q)
            INV_IDLE: begin
                if (start_i) begin
                    state_d = INV_SEED;
                end
            end
            INV_SEED: begin
                // e = 2 - d*x0
                req_valid_o = 1'b1;
                state_d     = INV_ERR_OP;
            end
            INV_ERR_OP: begin
                if (mac_valid_i) begin
                    req_valid_o = 1'b1;
                    a_o         = x_q;
                    b_o         = mac_res_i;
                    c_o         = '0;
                    state_d     = INV_MUL_OP;
                end
            end
            INV_MUL_OP: begin
                if (mac_valid_i) begin
                    if (last_iter) begin
                        state_d = INV_DONE;
                    end else begin
                        req_valid_o = 1'b1;
                        b_o         = mac_res_i;
                        state_d     = INV_ERR_OP;
                    end
                end
            end
            INV_DONE: state_d = INV_IDLE;
            default:  state_d = INV_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= INV_IDLE;
            iter_q  <= '0;
            inv_q   <= '0;
        end else if (clear_i) begin
            state_q <= INV_IDLE;
            iter_q  <= '0;
            inv_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == INV_SEED) begin
                iter_q <= '0;
            end else if (state_q == INV_MUL_OP && mac_valid_i && !last_iter) begin
                iter_q <= iter_q + 1'b1;
            end
            // undo the normalization
            if (state_q == INV_DONE) begin
                inv_q <= x_q >>> sh_q;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == INV_IDLE && start_i) begin
            d_q  <= den_i >> sh_d;
            sh_q <= sh_d;
        end
        if (state_q == INV_SEED) begin
            x_q <= seed;
        end else if (state_q == INV_MUL_OP && mac_valid_i) begin
            x_q <= mac_res_i;
        end
    end

    assign done_o = state_q == INV_DONE;
    assign inv_o  = inv_q;

endmodule

`default_nettype wire

// File: hw/sfm_accumulator.sv
`include "sfm_defs.svh"
`default_nettype none

module sfm_accumulator
    import sfm_pkg::*;
(
    input  wire logic  clk_i,
    input  wire logic  rst_ni,
    input  wire logic  clear_i,
    input  wire logic  add_valid_i,
    input  wire add_t  add_i,
    input  wire logic  mul_valid_i,
    input  wire fact_t mul_i,
    input  wire logic  finish_i,
    output logic       ready_o,
    output logic       valid_o,
    output logic       reducing_o,
    output acc_t       acc_o
);

    logic  sum_req_valid;
    acc_t  sum_a;
    acc_t  sum_b;
    acc_t  sum_c;
    slot_t sum_slot;
    logic  inv_req_valid;
    acc_t  inv_a;
    acc_t  inv_b;
    acc_t  inv_c;
    logic  mac_valid;
    acc_t  mac_res;
    slot_t mac_slot;
    logic  inv_start;
    logic  inv_done;
    acc_t  den;

    sfm_sum_ctrl u_sum_ctrl (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .clear_i     (clear_i),
        .add_valid_i (add_valid_i),
        .add_i       (add_i),
        .mul_valid_i (mul_valid_i),
        .mul_i       (mul_i),
        .finish_i    (finish_i),
        .inv_done_i  (inv_done),
        .mac_valid_i (mac_valid),
        .mac_res_i   (mac_res),
        .mac_slot_i  (mac_slot),
        .req_valid_o (sum_req_valid),
        .a_o         (sum_a),
        .b_o         (sum_b),
        .c_o         (sum_c),
        .slot_o      (sum_slot),
        .inv_start_o (inv_start),
        .den_o       (den),
        .ready_o     (ready_o),
        .valid_o     (valid_o),
        .reducing_o  (reducing_o)
    );

    sfm_inv_newton u_inv_newton (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .clear_i     (clear_i),
        .start_i     (inv_start),
        .den_i       (den),
        .mac_valid_i (mac_valid),
        .mac_res_i   (mac_res),
        .req_valid_o (inv_req_valid),
        .a_o         (inv_a),
        .b_o         (inv_b),
        .c_o         (inv_c),
        .done_o      (inv_done),
        .inv_o       (acc_o)
    );

    sfm_mac_pipe u_mac_pipe (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .clear_i         (clear_i),
        .sum_req_valid_i (sum_req_valid),
        .sum_a_i         (sum_a),
        .sum_b_i         (sum_b),
        .sum_c_i         (sum_c),
        .sum_slot_i      (sum_slot),
        .inv_req_valid_i (inv_req_valid),
        .inv_a_i         (inv_a),
        .inv_b_i         (inv_b),
        .inv_c_i         (inv_c),
        .mac_valid_o     (mac_valid),
        .mac_res_o       (mac_res),
        .mac_slot_o      (mac_slot)
    );

endmodule

`default_nettype wire

// File: verification/tb_sfm_accumulator.sv
`include "sfm_defs.svh"
`default_nettype none

module tb_sfm_accumulator
    import sfm_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int  CLK_PERIOD    = 8;
    localparam int  STAGES        = `SFM_MAC_STAGES;
    localparam int  N_TESTS       = 5;
    localparam int  MAX_ADDENDS   = 20;
    localparam int  RUN_CYCLES    = MAX_ADDENDS + 40;
    localparam int  RUNS_PER_TEST = 2;
    localparam int  TIMEOUT_NS    = (N_TESTS * RUNS_PER_TEST * RUN_CYCLES + 200) * CLK_PERIOD;
    localparam real TOL           = 1.0 / 128.0;

    logic  clk_i;
    logic  rst_ni;
    logic  clear_i;
    logic  add_valid_i;
    add_t  add_i;
    logic  mul_valid_i;
    fact_t mul_i;
    logic  finish_i;
    logic  ready_o;
    logic  valid_o;
    logic  reducing_o;
    acc_t  acc_o;

    logic [31:0] lfsr_q;
    bit          op_is_fact[$];
    int          op_val[$];
    real         exp_sum;
    int          errors;
    int          checks;
    int          tests_failed;
    int          chk_errors;
    int          chk_checks;
    int          results_seen;
    logic        valid_q;

    sfm_accumulator dut_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .clear_i     (clear_i),
        .add_valid_i (add_valid_i),
        .add_i       (add_i),
        .mul_valid_i (mul_valid_i),
        .mul_i       (mul_i),
        .finish_i    (finish_i),
        .ready_o     (ready_o),
        .valid_o     (valid_o),
        .reducing_o  (reducing_o),
        .acc_o       (acc_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
    endtask

    // ideal sum of the run where a factor scales all that came before it
    function automatic real ref_sum();
        real s;
        s = 0.0;
        foreach (op_val[i]) begin
            if (op_is_fact[i]) begin
                s = s * ($itor(op_val[i]) / 32768.0);
            end else begin
                s = s + ($itor(op_val[i]) / 65536.0);
            end
        end
        return s;
    endfunction

    task automatic check_bit(input string name, input logic actual, input logic expected);
        checks++;
        assert (actual === expected) else begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic start_run();
        op_is_fact.delete();
        op_val.delete();
    endtask

    // called on a falling edge, returns on the next one
    task automatic push_addend();
        logic [31:0] r;
        draw_bits(16, r);
        while (!ready_o) begin
            @(negedge clk_i);
        end
        add_valid_i = 1'b1;
        add_i       = add_t'(r[15:0] | 16'h4000);
        op_is_fact.push_back(1'b0);
        op_val.push_back(int'(add_i));
        @(negedge clk_i);
        add_valid_i = 1'b0;
    endtask

    task automatic push_factor();
        logic [31:0] r;
        int          low;
        draw_bits(15, r);
        while (!ready_o) begin
            @(negedge clk_i);
        end
        mul_valid_i = 1'b1;
        mul_i       = fact_t'({1'b0, r[14:0] | 15'h4000});
        op_is_fact.push_back(1'b1);
        op_val.push_back(int'(mul_i));
        @(negedge clk_i);
        mul_valid_i = 1'b0;
        low         = 0;
        while (!ready_o && low <= STAGES + 4) begin
            low++;
            @(negedge clk_i);
        end
        checks++;
        assert (low == STAGES) else begin
            $display("ERROR ready_o low cycles expected %h actual %h", STAGES, low);
            errors++;
        end
    endtask

    // finish pulse, then watch the flags until the checker has the result
    task automatic finish_run();
        bit saw_reducing;
        bit ready_leak;
        int target;
        exp_sum      = ref_sum();
        target       = results_seen + 1;
        saw_reducing = 1'b0;
        ready_leak   = 1'b0;
        finish_i     = 1'b1;
        @(negedge clk_i);
        finish_i = 1'b0;
        while (!valid_o) begin
            if (reducing_o) begin
                saw_reducing = 1'b1;
            end
            if (ready_o) begin
                ready_leak = 1'b1;
            end
            @(negedge clk_i);
        end
        checks += 2;
        assert (saw_reducing) else begin
            $display("reducing_o never rose between finish_i and valid_o");
            errors++;
        end
        assert (!ready_leak) else begin
            $display("ready_o went high between finish_i and valid_o");
            errors++;
        end
        check_bit("reducing_o", reducing_o, 1'b0);
        while (results_seen != target) begin
            @(negedge clk_i);
        end
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        if (errors + chk_errors == err_before) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors + chk_errors - err_before);
            tests_failed++;
        end
    endtask

    // compares acc_o once per rising valid_o
    always @(posedge clk_i) begin : check_result
        real prod;
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_o;
            if (valid_o && !valid_q) begin
                prod = $itor(acc_o) / 65536.0 * exp_sum;
                chk_checks++;
                assert (prod > 1.0 - TOL && prod < 1.0 + TOL) else begin
                    $display("ERROR acc_o expected %h actual %h",
                             acc_t'($rtoi(65536.0 / exp_sum)), acc_o);
                    chk_errors++;
                end
                results_seen++;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, the DUT stopped responding", TIMEOUT_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int err0;
        int wait_cnt;
        lfsr_q       = 32'h9921e1d4;
        errors       = 0;
        checks       = 0;
        tests_failed = 0;
        chk_errors   = 0;
        chk_checks   = 0;
        results_seen = 0;
        exp_sum      = 1.0;
        rst_ni       = 1'b0;
        clear_i      = 1'b0;
        add_valid_i  = 1'b0;
        add_i        = '0;
        mul_valid_i  = 1'b0;
        mul_i        = '0;
        finish_i     = 1'b0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        @(negedge clk_i);

        err0 = errors + chk_errors;
        start_run();
        repeat (MAX_ADDENDS) push_addend();
        finish_run();
        report_test(1, "plain accumulation", err0);

        err0 = errors + chk_errors;
        start_run();
        repeat (10) push_addend();
        push_factor();
        repeat (10) push_addend();
        finish_run();
        report_test(2, "rescale", err0);

        // result stays put until the next run
        err0 = errors + chk_errors;
        start_run();
        repeat (12) push_addend();
        finish_run();
        repeat (6) begin
            check_bit("valid_o", valid_o, 1'b1);
            check_bit("reducing_o", reducing_o, 1'b0);
            check_bit("ready_o", ready_o, 1'b1);
            @(negedge clk_i);
        end
        report_test(3, "reduction flag and back-pressure", err0);

        // clear hits while the slots are being reduced
        err0 = errors + chk_errors;
        start_run();
        repeat (12) push_addend();
        finish_i = 1'b1;
        @(negedge clk_i);
        finish_i = 1'b0;
        wait_cnt = 0;
        while (!reducing_o && wait_cnt < 4 * STAGES) begin
            wait_cnt++;
            @(negedge clk_i);
        end
        checks++;
        assert (reducing_o) else begin
            $display("reducing_o did not rise after finish_i");
            errors++;
        end
        clear_i = 1'b1;
        @(negedge clk_i);
        clear_i = 1'b0;
        check_bit("valid_o", valid_o, 1'b0);
        check_bit("reducing_o", reducing_o, 1'b0);
        check_bit("ready_o", ready_o, 1'b1);
        start_run();
        repeat (16) push_addend();
        finish_run();
        report_test(4, "clear mid-run", err0);

        err0 = errors + chk_errors;
        start_run();
        repeat (10) push_addend();
        finish_run();
        start_run();
        check_bit("valid_o", valid_o, 1'b1);
        push_addend();
        check_bit("valid_o", valid_o, 1'b0);
        repeat (11) push_addend();
        finish_run();
        report_test(5, "back-to-back runs", err0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d", N_TESTS, tests_failed,
                 checks + chk_checks, errors + chk_errors);
        if (errors + chk_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+hw
hw/sfm_pkg.sv
hw/sfm_mac_pipe.sv
hw/sfm_sum_ctrl.sv
hw/sfm_inv_newton.sv
hw/sfm_accumulator.sv
verification/tb_sfm_accumulator.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_sfm_accumulator
FILELIST  := src.f
OBJ_DIR   := obj_dir
PASS_MSG  := TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
